// File: src.f
+incdir+.
ctrl_pkg.sv
ctrl_bus_if.sv
req_router.sv
clint_timer.sv
debug_gate.sv
ctrl_subsys.sv
tb_ctrl_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the control subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f src.f --top-module tb_ctrl_subsys \
  --Mdir obj_dir -o tb_ctrl_subsys > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_ctrl_subsys > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: tb_ctrl_model.svh
/*
  Control subsystem reference model
  Register map, timer and debug gate state of the testbench, the
  xorshift generator and the typed compare tasks.
*/
`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

logic [31:0] rng_state = 32'd40;

mtime_t      m_mtime;
mtime_t      m_mtimecmp;
logic        m_msip;
logic        m_halt;
logic        m_rtc_div;

int unsigned data_errors;
int unsigned flag_errors;
int unsigned proto_errors;

// xorshift32, fixed seed
function automatic logic [31:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

function automatic addr_t reg_addr(input logic [3:0] region, input reg_idx_t idx);
  return {region, 6'd0, idx, 2'b00};
endfunction

task automatic model_reset();
  m_mtime    = '0;
  m_mtimecmp = '1;
  m_msip     = 1'b0;
  m_halt     = 1'b0;
  m_rtc_div  = 1'b0;
endtask

// mtime moves on every second rtc rising edge
task automatic model_rtc_rise();
  if (m_rtc_div) begin
    m_mtime = m_mtime + 64'd1;
  end
  m_rtc_div = ~m_rtc_div;
endtask

// issue_cyc is the clock count since reset when the request is driven
task automatic predict_access(input logic we, input addr_t addr, input data_t wdata,
                              input int unsigned issue_cyc,
                              output data_t rdata, output logic err);
  logic [3:0] region;
  reg_idx_t   idx;
  int         delay_left;
  region     = addr[15:12];
  idx        = addr[5:2];
  rdata      = '0;
  err        = 1'b0;
  delay_left = int'(DebugDelayCycles) - int'(issue_cyc) - 1;
  if (delay_left < 0) begin
    delay_left = 0;
  end
  if (region == 4'd0) begin
    if (we) begin
      case (idx)
        ClintMsip:       m_msip = wdata[0];
        ClintMtimeLo:    m_mtime[31:0] = wdata;
        ClintMtimeHi:    m_mtime[63:32] = wdata;
        ClintMtimecmpLo: m_mtimecmp[31:0] = wdata;
        ClintMtimecmpHi: m_mtimecmp[63:32] = wdata;
        default: ;
      endcase
    end else begin
      case (idx)
        ClintMsip:       rdata = {31'd0, m_msip};
        ClintMtimeLo:    rdata = m_mtime[31:0];
        ClintMtimeHi:    rdata = m_mtime[63:32];
        ClintMtimecmpLo: rdata = m_mtimecmp[31:0];
        ClintMtimecmpHi: rdata = m_mtimecmp[63:32];
        default:         rdata = '0;
      endcase
    end
  end else if (region == 4'd1) begin
    if (we) begin
      if (idx == DbgHaltReq) begin
        m_halt = wdata[0];
      end
    end else if (idx == DbgHaltReq) begin
      rdata = {31'd0, m_halt};
    end else if (idx == DbgDelayLeft) begin
      rdata = data_t'(delay_left);
    end
  end else begin
    err = 1'b1;
  end
endtask

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_data(input string name, input data_t got, input data_t exp);
  if (got !== exp) begin
    data_errors++;
    $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
  end
endtask

task automatic check_err(input logic got, input logic exp);
  if (got !== exp) begin
    flag_errors++;
    $display("** Error at %0t: resp_err_o = %b, expected %b", $time, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    flag_errors++;
    $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
  end
endtask

`endif

// File: tb_ctrl_subsys.sv
/*
  Control subsystem testbench
  Random credit-limited requests against the router, timer and
  debug gate, checked against the reference model in order.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_subsys
  import ctrl_pkg::*;
();

  localparam int unsigned ResetCycles   = 10;
  localparam int unsigned HoldoffCycles = DebugDelayCycles + 12;
  localparam int unsigned RandRequests  = 150;
  localparam int unsigned MapRequests   = 60;
  localparam int unsigned TimerRounds   = 6;
  localparam int unsigned RoundCycles   = 90;
  localparam int unsigned HaltCycles    = 40;
  localparam int unsigned MarginCycles  = 300;
  localparam int unsigned TimeoutCycles = ResetCycles + HoldoffCycles + RandRequests +
                                          MapRequests + TimerRounds * RoundCycles +
                                          HaltCycles + MarginCycles;

  logic        clk_i;
  logic        ndmreset_n;
  logic        rtc_i;
  logic        req_valid_i;
  logic        req_we_i;
  addr_t       req_addr_i;
  data_t       req_wdata_i;
  logic        debug_req_i;
  logic        resp_valid_o;
  data_t       resp_rdata_o;
  logic        resp_err_o;
  logic        credit_o;
  logic        timer_irq_o;
  logic        ipi_o;
  logic        debug_req_o;

  int unsigned cycle_cnt;
  int unsigned watchdog_cnt;
  int          credits;
  data_t       exp_rdata_q[$];
  logic        exp_err_q[$];
  int unsigned exp_cyc_q[$];

  `include "tb_ctrl_model.svh"

  ctrl_subsys i_ctrl_subsys (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .rtc_i        ( rtc_i        ),
    .req_valid_i  ( req_valid_i  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_wdata_i  ( req_wdata_i  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_rdata_o ( resp_rdata_o ),
    .resp_err_o   ( resp_err_o   ),
    .credit_o     ( credit_o     ),
    .debug_req_i  ( debug_req_i  ),
    .timer_irq_o  ( timer_irq_o  ),
    .ipi_o        ( ipi_o        ),
    .debug_req_o  ( debug_req_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // clock edges since reset release
  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  // ----------------------------------------
  // response side
  // ----------------------------------------
  task automatic observe_outputs();
    data_t       exp_rdata;
    logic        exp_err;
    int unsigned issued;
    if (credit_o !== resp_valid_o) begin
      proto_errors++;
      $display("credit_o and resp_valid_o disagree at %0t, a credit went missing", $time);
    end
    if (credit_o === 1'b1) begin
      credits++;
    end
    if (credits > int'(ReqCredits)) begin
      proto_errors++;
      $display("more credits returned than requests issued at %0t", $time);
      credits = ReqCredits;
    end
    if (resp_valid_o === 1'b1) begin
      if (exp_cyc_q.size() == 0) begin
        proto_errors++;
        $display("response at %0t with no request outstanding", $time);
      end else begin
        exp_rdata = exp_rdata_q.pop_front();
        exp_err   = exp_err_q.pop_front();
        issued    = exp_cyc_q.pop_front();
        if (cycle_cnt - issued != 2) begin
          proto_errors++;
          $display("response at %0t came %0d cycles after its request instead of 2",
                   $time, cycle_cnt - issued);
        end
        check_data("resp_rdata_o", resp_rdata_o, exp_rdata);
        check_err(resp_err_o, exp_err);
      end
    end else if (exp_cyc_q.size() != 0 && cycle_cnt - exp_cyc_q[0] > 2) begin
      proto_errors++;
      $display("request issued at cycle %0d never got a response", exp_cyc_q[0]);
      void'(exp_rdata_q.pop_front());
      void'(exp_err_q.pop_front());
      void'(exp_cyc_q.pop_front());
      credits++;
    end
  endtask

  // ----------------------------------------
  // request side
  // ----------------------------------------
  task automatic step_idle();
    @(negedge clk_i);
    observe_outputs();
    req_valid_i = 1'b0;
  endtask

  task automatic issue(input logic we, input addr_t addr, input data_t wdata);
    data_t exp_rdata;
    logic  exp_err;
    @(negedge clk_i);
    observe_outputs();
    // hold back until a credit comes home
    while (credits == 0) begin
      req_valid_i = 1'b0;
      @(negedge clk_i);
      observe_outputs();
    end
    predict_access(we, addr, wdata, cycle_cnt, exp_rdata, exp_err);
    exp_rdata_q.push_back(exp_rdata);
    exp_err_q.push_back(exp_err);
    exp_cyc_q.push_back(cycle_cnt);
    credits--;
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
  endtask

  task automatic drain();
    step_idle();
    while (exp_cyc_q.size() != 0) begin
      step_idle();
    end
  endtask

  // irq is one cycle behind its inputs, so settle first
  task automatic check_quiet_outputs();
    repeat (4) step_idle();
    check_bit("timer_irq_o", timer_irq_o, m_mtime >= m_mtimecmp);
    check_bit("ipi_o", ipi_o, m_msip);
    check_bit("debug_req_o", debug_req_o,
              (cycle_cnt >= DebugDelayCycles) && (debug_req_i || m_halt));
  endtask

  task automatic pulse_rtc(input int unsigned rises);
    for (int unsigned i = 0; i < rises; i++) begin
      step_idle();
      rtc_i = 1'b1;
      model_rtc_rise();
      repeat (2) step_idle();
      step_idle();
      rtc_i = 1'b0;
      repeat (2) step_idle();
    end
  endtask

  initial begin : watchdog
    watchdog_cnt = 0;
    while (watchdog_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      watchdog_cnt++;
    end
    $display("timeout, the run did not finish within %0d cycles", TimeoutCycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main_seq
    logic [31:0] r;
    logic [3:0]  region;
    reg_idx_t    idx;
    data_t       base;
    ndmreset_n   = 1'b0;
    rtc_i        = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    debug_req_i  = 1'b1;
    credits      = 0;
    data_errors  = 0;
    flag_errors  = 0;
    proto_errors = 0;
    model_reset();

    repeat (ResetCycles) @(negedge clk_i);
    check_bit("resp_valid_o", resp_valid_o, 1'b0);
    check_bit("credit_o", credit_o, 1'b0);
    check_bit("timer_irq_o", timer_irq_o, 1'b0);
    check_bit("ipi_o", ipi_o, 1'b0);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    ndmreset_n = 1'b1;
    credits    = ReqCredits;

    // ----------------------------------------
    // debug hold-off with debug_req_i high
    // ----------------------------------------
    for (int unsigned i = 0; i < HoldoffCycles; i++) begin
      r = next_random();
      if (r[1:0] == 2'b00) begin
        issue(1'b0, reg_addr(4'd1, (r[3:2] != 0) ? DbgDelayLeft : DbgHaltReq), '0);
      end else begin
        step_idle();
      end
      check_bit("debug_req_o", debug_req_o, cycle_cnt >= DebugDelayCycles);
    end
    drain();
    debug_req_i = 1'b0;

    // back to back random traffic on the mapped regions
    for (int unsigned i = 0; i < RandRequests; i++) begin
      r = next_random();
      issue(r[13], {3'b000, r[16], r[11:0]}, next_random());
    end
    drain();
    check_quiet_outputs();

    // unmapped regions and unknown indices
    for (int unsigned i = 0; i < MapRequests; i++) begin
      r = next_random();
      if (r[0]) begin
        region = 4'(2 + r[7:4] % 14);
        issue(r[3], {region, r[19:8]}, next_random());
      end else begin
        if (r[1]) begin
          idx = 4'(2 + r[11:8] % 14);
        end else begin
          idx = r[2] ? 4'd1 : 4'(6 + r[11:8] % 10);
        end
        issue(1'b0, reg_addr({3'b000, r[1]}, idx), '0);
      end
    end
    drain();
    check_quiet_outputs();

    // ----------------------------------------
    // timer rounds
    // ----------------------------------------
    for (int unsigned n = 0; n < TimerRounds; n++) begin
      r    = next_random();
      base = {16'd0, r[15:0]};
      issue(1'b1, reg_addr(4'd0, ClintMsip), {31'd0, r[16]});
      issue(1'b1, reg_addr(4'd0, ClintMtimeHi), '0);
      issue(1'b1, reg_addr(4'd0, ClintMtimeLo), base);
      issue(1'b1, reg_addr(4'd0, ClintMtimecmpHi), '0);
      issue(1'b1, reg_addr(4'd0, ClintMtimecmpLo), base + data_t'(r[19:17]));
      issue(1'b0, reg_addr(4'd0, ClintMsip), '0);
      issue(1'b0, reg_addr(4'd0, ClintMtimecmpLo), '0);
      issue(1'b0, reg_addr(4'd0, ClintMtimecmpHi), '0);
      drain();
      pulse_rtc(2 + r[22:20]);
      check_quiet_outputs();
      issue(1'b0, reg_addr(4'd0, ClintMtimeLo), '0);
      issue(1'b0, reg_addr(4'd0, ClintMtimeHi), '0);
      drain();
    end

    // halt request with debug_req_i low
    issue(1'b1, reg_addr(4'd1, DbgHaltReq), 32'd1);
    issue(1'b0, reg_addr(4'd1, DbgHaltReq), '0);
    drain();
    check_quiet_outputs();
    check_bit("debug_req_o", debug_req_o, 1'b1);
    issue(1'b1, reg_addr(4'd1, DbgHaltReq), 32'd0);
    issue(1'b0, reg_addr(4'd1, DbgHaltReq), '0);
    drain();
    check_quiet_outputs();
    check_bit("debug_req_o", debug_req_o, 1'b0);

    $display("errors: data %0d, flags %0d, protocol %0d",
             data_errors, flag_errors, proto_errors);
    if (data_errors + flag_errors + proto_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ctrl_subsys.sv
/*
  Control subsystem top
  Request router in front of the core-local timer and the debug
  request gate.
*/
`timescale 1ns/1ps
`default_nettype none

module ctrl_subsys
  import ctrl_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  ndmreset_n,
  input  wire logic  rtc_i,

  // request port
  input  wire logic  req_valid_i,
  input  wire logic  req_we_i,
  input  wire addr_t req_addr_i,
  input  wire data_t req_wdata_i,

  // response port
  output logic       resp_valid_o,
  output data_t      resp_rdata_o,
  output logic       resp_err_o,
  output logic       credit_o,

  // core side
  input  wire logic  debug_req_i,
  output logic       timer_irq_o,
  output logic       ipi_o,
  output logic       debug_req_o
);

  ctrl_bus_if clint_bus ();
  ctrl_bus_if dbg_bus ();

  req_router i_req_router (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .req_valid_i  ( req_valid_i  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_wdata_i  ( req_wdata_i  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_rdata_o ( resp_rdata_o ),
    .resp_err_o   ( resp_err_o   ),
    .credit_o     ( credit_o     ),
    .clint_bus    ( clint_bus    ),
    .dbg_bus      ( dbg_bus      )
  );

  // ----------------------------------------
  // slaves
  // ----------------------------------------
  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .bus         ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .bus         ( dbg_bus     ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

// File: debug_gate.sv
/*
  Debug request gate
  Holds off the debug request for a fixed window after reset so boot
  code can run, and adds a software halt-request bit.
*/
`timescale 1ns/1ps
`default_nettype none

module debug_gate
  import ctrl_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic ndmreset_n,
  input  wire logic debug_req_i,

  ctrl_bus_if.slave bus,

  output logic      debug_req_o
);

  logic [DelayCntW-1:0] delay_cnt_q;
  logic                 delay_busy;
  logic                 halt_req_q;
  data_t                rd_word;
  data_t                rdata_q;

  // ----------------------------------------
  // hold-off counter
  // ----------------------------------------
  assign delay_busy = (delay_cnt_q != '0);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      delay_cnt_q <= DelayCntW'(DebugDelayCycles);
      halt_req_q  <= 1'b0;
    end else begin
      if (delay_busy) begin
        delay_cnt_q <= delay_cnt_q - 1'b1;
      end
      if (bus.sel && bus.we && bus.reg_idx == DbgHaltReq) begin
        halt_req_q <= bus.wdata[0];
      end
    end
  end

  // nothing reaches the core while the window is open
  assign debug_req_o = delay_busy ? 1'b0 : (debug_req_i | halt_req_q);

  // ----------------------------------------
  // read back
  // ----------------------------------------
  always_comb begin
    case (bus.reg_idx)
      DbgHaltReq:   rd_word = {31'd0, halt_req_q};
      DbgDelayLeft: rd_word = data_t'(delay_cnt_q);
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.sel) begin
      rdata_q <= bus.we ? '0 : rd_word;
    end
  end

  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: clint_timer.sv
/*
  Core-local timer
  64-bit mtime counting at half the synchronised rtc rate, 64-bit
  mtimecmp and the msip bit, with timer and software interrupts.
*/
`timescale 1ns/1ps
`default_nettype none

module clint_timer
  import ctrl_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic ndmreset_n,
  input  wire logic rtc_i,

  ctrl_bus_if.slave bus,

  output logic      timer_irq_o,
  output logic      ipi_o
);

  logic [1:0] rtc_sync_q;
  logic       rtc_prev_q;
  logic       rtc_div_q;
  logic       rtc_rise;
  logic       mtime_tick;

  mtime_t     mtime_q;
  mtime_t     mtimecmp_q;
  logic       msip_q;
  logic       timer_irq_q;
  logic       wr_en;
  data_t      rd_word;
  data_t      rdata_q;

  // ----------------------------------------
  // rtc sync and divide by two
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_div_q <= ~rtc_div_q;
      end
    end
  end

  assign rtc_rise   = rtc_sync_q[1] & ~rtc_prev_q;
  // every second rising edge
  assign mtime_tick = rtc_rise & rtc_div_q;

  // ----------------------------------------
  // registers
  // ----------------------------------------
  assign wr_en = bus.sel & bus.we;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= MtimecmpReset;
      msip_q     <= 1'b0;
    end else begin
      // a software write to mtime wins over the tick
      if (wr_en && bus.reg_idx == ClintMtimeLo) begin
        mtime_q <= {mtime_q[63:32], bus.wdata};
      end else if (wr_en && bus.reg_idx == ClintMtimeHi) begin
        mtime_q <= {bus.wdata, mtime_q[31:0]};
      end else if (mtime_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end

      if (wr_en && bus.reg_idx == ClintMtimecmpLo) begin
        mtimecmp_q[31:0] <= bus.wdata;
      end
      if (wr_en && bus.reg_idx == ClintMtimecmpHi) begin
        mtimecmp_q[63:32] <= bus.wdata;
      end
      if (wr_en && bus.reg_idx == ClintMsip) begin
        msip_q <= bus.wdata[0];
      end
    end
  end

  // read mux, unknown indices read as zero
  always_comb begin
    case (bus.reg_idx)
      ClintMsip:       rd_word = {31'd0, msip_q};
      ClintMtimeLo:    rd_word = mtime_q[31:0];
      ClintMtimeHi:    rd_word = mtime_q[63:32];
      ClintMtimecmpLo: rd_word = mtimecmp_q[31:0];
      ClintMtimecmpHi: rd_word = mtimecmp_q[63:32];
      default:         rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.sel) begin
      rdata_q <= bus.we ? '0 : rd_word;
    end
  end

  assign bus.rdata = rdata_q;

  // ----------------------------------------
  // interrupts
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      timer_irq_q <= 1'b0;
    end else begin
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// File: req_router.sv
/*
  Request router
  Two-stage pipeline: stage 1 decodes the region and drives sel on
  one slave bus, stage 2 picks that slave's read data, flags
  unmapped regions and returns one credit with each response.
*/
`timescale 1ns/1ps
`default_nettype none

module req_router
  import ctrl_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  ndmreset_n,

  // request port
  input  wire logic  req_valid_i,
  input  wire logic  req_we_i,
  input  wire addr_t req_addr_i,
  input  wire data_t req_wdata_i,

  // response port
  output logic       resp_valid_o,
  output data_t      resp_rdata_o,
  output logic       resp_err_o,
  output logic       credit_o,

  ctrl_bus_if.master clint_bus,
  ctrl_bus_if.master dbg_bus
);

  region_e  req_region;
  logic     hit_clint;
  logic     hit_dbg;

  logic     s1_valid_q;
  logic     s1_clint_q;
  logic     s1_dbg_q;
  logic     s1_we_q;
  reg_idx_t s1_idx_q;
  data_t    s1_wdata_q;

  logic     s2_valid_q;
  logic     s2_dbg_q;
  logic     s2_we_q;
  logic     s2_err_q;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  assign req_region = region_e'(req_addr_i[RegionLsb +: RegionW]);

  always_comb begin
    hit_clint = 1'b0;
    hit_dbg   = 1'b0;
    case (req_region)
      RegionClint: hit_clint = 1'b1;
      RegionDebug: hit_dbg   = 1'b1;
      default: ;
    endcase
  end

  // ----------------------------------------
  // stage 1
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      s1_valid_q <= 1'b0;
      s1_clint_q <= 1'b0;
      s1_dbg_q   <= 1'b0;
    end else begin
      s1_valid_q <= req_valid_i;
      s1_clint_q <= req_valid_i & hit_clint;
      s1_dbg_q   <= req_valid_i & hit_dbg;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_we_q    <= req_we_i;
    s1_idx_q   <= req_addr_i[IdxLsb +: IdxW];
    s1_wdata_q <= req_wdata_i;
  end

  // both buses see the same access, only sel differs
  assign clint_bus.sel     = s1_clint_q;
  assign clint_bus.we      = s1_we_q;
  assign clint_bus.reg_idx = s1_idx_q;
  assign clint_bus.wdata   = s1_wdata_q;

  assign dbg_bus.sel     = s1_dbg_q;
  assign dbg_bus.we      = s1_we_q;
  assign dbg_bus.reg_idx = s1_idx_q;
  assign dbg_bus.wdata   = s1_wdata_q;

  // ----------------------------------------
  // stage 2
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      s2_valid_q <= 1'b0;
      s2_dbg_q   <= 1'b0;
      s2_we_q    <= 1'b0;
      s2_err_q   <= 1'b0;
    end else begin
      s2_valid_q <= s1_valid_q;
      s2_dbg_q   <= s1_dbg_q;
      s2_we_q    <= s1_we_q;
      s2_err_q   <= s1_valid_q & ~(s1_clint_q | s1_dbg_q);
    end
  end

  // slave rdata is registered, so it lines up with stage 2
  always_comb begin
    resp_rdata_o = '0;
    if (s2_valid_q && !s2_err_q && !s2_we_q) begin
      resp_rdata_o = s2_dbg_q ? dbg_bus.rdata : clint_bus.rdata;
    end
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_err_o   = s2_valid_q & s2_err_q;
  // one credit back per response
  assign credit_o     = s2_valid_q;

endmodule

`default_nettype wire

// File: ctrl_bus_if.sv
/*
  Router to slave access bus
  One decoded register access per cycle marked by sel, with the
  slave's registered read data returned in the following cycle.
*/
`timescale 1ns/1ps
`default_nettype none

interface ctrl_bus_if
  import ctrl_pkg::*;
();

  logic     sel;
  logic     we;
  reg_idx_t reg_idx;
  data_t    wdata;
  data_t    rdata;

  // router side
  modport master (
    output sel,
    output we,
    output reg_idx,
    output wdata,
    input  rdata
  );

  // register block side
  modport slave (
    input  sel,
    input  we,
    input  reg_idx,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: ctrl_pkg.sv
/*
  Control subsystem package
  Bus widths, the region address map, per-region register indices,
  the request credit count and the reset values of the timer and
  the debug hold-off counter.
*/
`default_nettype none

package ctrl_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int unsigned AddrW   = 16;
  localparam int unsigned DataW   = 32;
  localparam int unsigned RegionW = 4;
  localparam int unsigned IdxW    = 4;
  localparam int unsigned MtimeW  = 64;

  // address fields: region in 15..12, register word in 5..2
  localparam int unsigned RegionLsb = 12;
  localparam int unsigned IdxLsb    = 2;

  typedef logic [AddrW-1:0]  addr_t;
  typedef logic [DataW-1:0]  data_t;
  typedef logic [IdxW-1:0]   reg_idx_t;
  typedef logic [MtimeW-1:0] mtime_t;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  // any other region value is unmapped and answers with an error
  typedef enum logic [RegionW-1:0] {
    RegionClint = 4'd0,
    RegionDebug = 4'd1
  } region_e;

  // clint registers
  localparam reg_idx_t ClintMsip       = 4'd0;
  localparam reg_idx_t ClintMtimeLo    = 4'd2;
  localparam reg_idx_t ClintMtimeHi    = 4'd3;
  localparam reg_idx_t ClintMtimecmpLo = 4'd4;
  localparam reg_idx_t ClintMtimecmpHi = 4'd5;

  // debug gate registers
  // halt request lives in bit 0, delay left is read only
  localparam reg_idx_t DbgHaltReq   = 4'd0;
  localparam reg_idx_t DbgDelayLeft = 4'd1;

  // ----------------------------------------
  // flow control and reset values
  // ----------------------------------------
  // credits held by the requester after reset
  localparam int unsigned ReqCredits = 2;

  // boot window before a debug request may reach the core
  localparam int unsigned DebugDelayCycles = 64;
  localparam int unsigned DelayCntW        = $clog2(DebugDelayCycles + 1);

  // no timer interrupt until software programs a compare value
  localparam mtime_t MtimecmpReset = {MtimeW{1'b1}};

endpackage

`default_nettype wire
